//--- bench/rtsStim.txt
// destAddr srcAddr duration bwSignaling pwrMgt mode busyDensity abort, all hex
// mode 0 PIFS, 1 SIFS, 2 slot; busyDensity in sixteenths; abort 1 soft-resets mid-frame
0123456789ab a1b2c3d4e5f6 002c 0 0 0 0 0
ffeeddccbbaa 102030405060 0130 1 0 1 0 0
5a5a5a5a5a5a 0000000000c3 7fff 0 1 2 3 0
001122334455 66778899aabb 00a0 1 1 0 6 0
deadbeef0001 cafef00d0002 1234 0 0 1 8 1
8000000000fe 0000000000ff 8001 0 1 2 5 0
13579bdf2468 2468ace01357 0044 1 0 2 a 0
0f0f0f0f0f0f f0f0f0f0f0f0 ffff 0 1 0 c 1
111111111111 222222222222 0000 1 1 1 4 0
7e7e7e7e7e7e 818181818181 3c3c 0 0 0 2 0
000000000000 fffffffffffe 0101 1 1 2 9 0
abcdefabcdef fedcbafedcba 0202 0 1 1 7 0

//--- sim.f
hdl/rtsPkg.sv
hdl/rtsIfsTrigger.sv
hdl/rtsFieldSequencer.sv
hdl/rtsByteMux.sv
hdl/rtsFormatter.sv
bench/rtsTb.sv

//--- run.sh
#!/bin/sh
# Build the RTS formatter testbench with Verilator, run it, look for the pass line
verilator --binary --timing --top-module rtsTb -f sim.f -o rtsSim \
  && ./obj_dir/rtsSim | tee /dev/stderr | grep -q "^Everything OK$" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

//--- bench/rtsTb.sv
`timescale 1ns/1ps

module rtsTb;

  // Room for the records of the stimulus file
  localparam int maxRecords = 16;
  // Hex words per record
  localparam int recWords   = 8;
  // Upper bound on any wait, in cycles
  localparam int waitLimit  = 400;

  // DUT inputs
  logic        macCoreTxClk;
  logic        macCoreClkHardRst_n;
  logic        macCoreTxClkSoftRst_n;
  logic [47:0] destAddr;
  logic [47:0] srcAddr;
  logic [15:0] duration;
  logic        txBWSignaling;
  logic        pwrMgt;
  logic        sendRTS_p;
  logic        sendOnPIFS;
  logic        sendOnSIFS;
  logic        tickSIFS;
  logic        tickPIFS_p;
  logic        tickSlot_p;
  // Driven by the FCS engine model
  logic        fcsBusy  = 1'b0;
  logic        fcsEnd_p = 1'b0;

  // DUT outputs
  logic        rtsDone_p;
  logic        rtsTxStart_p;
  logic        rtsFCSEnable;
  logic        rtsFCSStart_p;
  logic        rtsFCSShiftTx;
  logic [7:0]  rtsFCSDInTx;
  logic        rtsFCSDInValidTx;

  // Stimulus image and current record
  logic [63:0] stimMem [0:maxRecords*recWords-1];
  logic [3:0]  busyDensity = 4'd0;
  logic [1:0]  mode;
  logic        abortFrame;
  // Expected header and bytes seen by the engine
  logic [7:0]  expBytes [0:15];
  logic [7:0]  captured [$];

  // FCS engine model state
  integer      seed = 31;
  integer      randVal;
  int          shiftCnt = 0;
  // Byte monitor state
  logic        dataPhase = 1'b0;
  logic        holdNext  = 1'b0;
  logic [7:0]  prevByte  = 8'd0;

  int          checkCount    = 0;
  int          mismatchCount = 0;
  int          otherErrCount = 0;
  int          rec;
  int          i;

  rtsFormatter u_dut (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .destAddr              (destAddr),
    .srcAddr               (srcAddr),
    .duration              (duration),
    .txBWSignaling         (txBWSignaling),
    .pwrMgt                (pwrMgt),
    .sendRTS_p             (sendRTS_p),
    .sendOnPIFS            (sendOnPIFS),
    .sendOnSIFS            (sendOnSIFS),
    .rtsDone_p             (rtsDone_p),
    .rtsTxStart_p          (rtsTxStart_p),
    .tickSIFS              (tickSIFS),
    .tickPIFS_p            (tickPIFS_p),
    .tickSlot_p            (tickSlot_p),
    .fcsBusy               (fcsBusy),
    .fcsEnd_p              (fcsEnd_p),
    .rtsFCSEnable          (rtsFCSEnable),
    .rtsFCSStart_p         (rtsFCSStart_p),
    .rtsFCSShiftTx         (rtsFCSShiftTx),
    .rtsFCSDInTx           (rtsFCSDInTx),
    .rtsFCSDInValidTx      (rtsFCSDInValidTx)
  );

  // 100 ns clock
  initial
  begin
    macCoreTxClk = 1'b0;
    forever #50 macCoreTxClk = ~macCoreTxClk;
  end

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      mismatchCount++;
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  ////////////////////////////////////////
  // FCS engine model
  ////////////////////////////////////////

  // Checksum cycles counted on the edge the DUT uses
  always @(posedge macCoreTxClk)
  begin
    if (rtsFCSShiftTx)
      shiftCnt <= shiftCnt + 1;
    else
      shiftCnt <= 0;
  end

  // Busy density counts in sixteenths
  always @(negedge macCoreTxClk)
  begin
    randVal  = $random(seed);
    fcsBusy  = (randVal[3:0] < busyDensity);
    // Checksum done three cycles into the shift
    fcsEnd_p = (shiftCnt == 3);
  end

  ////////////////////////////////////////
  // Byte monitor
  ////////////////////////////////////////

  always @(posedge macCoreTxClk)
  begin
    if (macCoreClkHardRst_n)
    begin
      if (fcsBusy)
        checkValue("rtsFCSDInValidTx while fcsBusy", 64'(rtsFCSDInValidTx), 64'd0);
      // Byte frozen while the engine was busy
      if (holdNext)
        checkValue("rtsFCSDInTx through busy", 64'(rtsFCSDInTx), 64'(prevByte));
      if (rtsFCSDInValidTx)
      begin
        // Shift request goes up with the sixteenth byte only
        checkValue("rtsFCSShiftTx", 64'(rtsFCSShiftTx), 64'(captured.size() == 15));
        captured.push_back(rtsFCSDInTx);
      end
      holdNext = dataPhase && fcsBusy && macCoreTxClkSoftRst_n;
      prevByte = rtsFCSDInTx;
      if (!macCoreTxClkSoftRst_n || (rtsFCSDInValidTx && rtsFCSShiftTx))
        dataPhase = 1'b0;
      else if (rtsFCSStart_p)
        dataPhase = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Reference and stimulus tasks
  ////////////////////////////////////////

  // Header bytes in transmit order
  function automatic void buildExpected();
    int k;
    // Subtype 1011, control type 01, version 00
    expBytes[0] = {4'b1011, 2'b01, 2'b00};
    // Power management is bit 4 of the high byte
    expBytes[1] = {3'b000, pwrMgt, 4'b0000};
    expBytes[2] = duration[7:0];
    expBytes[3] = duration[15:8];
    for (k = 0; k < 6; k++)
    begin
      expBytes[4 + k]  = destAddr[8*k +: 8];
      expBytes[10 + k] = srcAddr[8*k +: 8];
    end
    // Bandwidth signaling forces the group bit of TA
    if (txBWSignaling)
      expBytes[10][0] = 1'b1;
  endfunction

  // 0 PIFS, 1 SIFS, 2 slot
  task automatic pulseTick(input logic [1:0] which, input logic expectStart);
    tickPIFS_p = (which == 2'd0);
    tickSIFS   = (which == 2'd1);
    tickSlot_p = (which == 2'd2);
    @(posedge macCoreTxClk);
    checkValue("rtsTxStart_p", 64'(rtsTxStart_p), 64'(expectStart));
    @(negedge macCoreTxClk);
    tickPIFS_p = 1'b0;
    tickSIFS   = 1'b0;
    tickSlot_p = 1'b0;
  endtask

  task automatic waitTransfers(input int target);
    int cycles;
    cycles = 0;
    while (captured.size() < target && cycles < waitLimit)
    begin
      @(negedge macCoreTxClk);
      cycles++;
    end
    if (captured.size() < target)
    begin
      $display("timeout: only %0d of %0d header bytes reached the FCS engine",
               captured.size(), target);
      otherErrCount++;
    end
  endtask

  task automatic runRecord(input int r);
    int b;
    int k;
    int cycles;
    logic endSeen;
    b = r * recWords;
    destAddr      = stimMem[b][47:0];
    srcAddr       = stimMem[b+1][47:0];
    duration      = stimMem[b+2][15:0];
    txBWSignaling = stimMem[b+3][0];
    pwrMgt        = stimMem[b+4][0];
    mode          = stimMem[b+5][1:0];
    busyDensity   = stimMem[b+6][3:0];
    abortFrame    = stimMem[b+7][0];
    sendOnPIFS    = (mode == 2'd0);
    sendOnSIFS    = (mode == 2'd1);
    buildExpected();
    captured.delete();
    // Engine enable follows the request one cycle later
    sendRTS_p = 1'b1;
    @(posedge macCoreTxClk);
    @(negedge macCoreTxClk);
    sendRTS_p = 1'b0;
    @(posedge macCoreTxClk);
    checkValue("rtsFCSEnable after request", 64'(rtsFCSEnable), 64'd1);
    @(negedge macCoreTxClk);
    // Other modes' ticks must be ignored
    if (mode != 2'd0)
      pulseTick(2'd0, 1'b0);
    if (mode != 2'd1)
      pulseTick(2'd1, 1'b0);
    if (mode != 2'd2)
      pulseTick(2'd2, 1'b0);
    pulseTick(mode, 1'b1);
    @(posedge macCoreTxClk);
    checkValue("rtsFCSStart_p", 64'(rtsFCSStart_p), 64'd1);
    @(negedge macCoreTxClk);
    if (abortFrame)
    begin
      // Soft reset in the middle of the RA field
      waitTransfers(5);
      macCoreTxClkSoftRst_n = 1'b0;
      @(posedge macCoreTxClk);
      @(negedge macCoreTxClk);
      macCoreTxClkSoftRst_n = 1'b1;
      @(posedge macCoreTxClk);
      checkValue("rtsFCSEnable after soft reset", 64'(rtsFCSEnable), 64'd0);
      checkValue("rtsFCSDInValidTx after soft reset", 64'(rtsFCSDInValidTx), 64'd0);
      @(negedge macCoreTxClk);
      for (k = 0; k < captured.size() && k < 16; k++)
        checkValue($sformatf("rtsFCSDInTx byte %0d", k), 64'(captured[k]), 64'(expBytes[k]));
    end
    else
    begin
      waitTransfers(16);
      cycles  = 0;
      endSeen = 1'b0;
      while (!endSeen && cycles < waitLimit)
      begin
        @(posedge macCoreTxClk);
        endSeen = fcsEnd_p;
        cycles++;
      end
      if (!endSeen)
      begin
        $display("timeout: no end of checksum from the FCS engine in record %0d", r);
        otherErrCount++;
      end
      else
      begin
        // Done comes one cycle after the end pulse
        checkValue("rtsDone_p with fcsEnd_p", 64'(rtsDone_p), 64'd0);
        @(posedge macCoreTxClk);
        checkValue("rtsDone_p", 64'(rtsDone_p), 64'd1);
        checkValue("rtsFCSEnable after done", 64'(rtsFCSEnable), 64'd0);
      end
      @(negedge macCoreTxClk);
      checkValue("transfer count", 64'(captured.size()), 64'd16);
      if (captured.size() == 16)
      begin
        for (k = 0; k < 16; k++)
          checkValue($sformatf("rtsFCSDInTx byte %0d", k), 64'(captured[k]), 64'(expBytes[k]));
        checkValue("pwrMgt bit", 64'(captured[1][4]), 64'(pwrMgt));
        if (txBWSignaling)
          checkValue("TA bandwidth bit", 64'(captured[10][0]), 64'd1);
        else
          checkValue("TA first byte", 64'(captured[10]), 64'(srcAddr[7:0]));
      end
    end
    // Engine stays off in the gap between frames
    @(posedge macCoreTxClk);
    checkValue("rtsFCSEnable idle", 64'(rtsFCSEnable), 64'd0);
    checkValue("rtsDone_p idle", 64'(rtsDone_p), 64'd0);
    @(negedge macCoreTxClk);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    macCoreClkHardRst_n   = 1'b0;
    macCoreTxClkSoftRst_n = 1'b1;
    destAddr      = 48'd0;
    srcAddr       = 48'd0;
    duration      = 16'd0;
    txBWSignaling = 1'b0;
    pwrMgt        = 1'b0;
    sendRTS_p     = 1'b0;
    sendOnPIFS    = 1'b0;
    sendOnSIFS    = 1'b0;
    tickSIFS      = 1'b0;
    tickPIFS_p    = 1'b0;
    tickSlot_p    = 1'b0;
    // Fill keeps mode words above 2 past the last record
    for (i = 0; i < maxRecords * recWords; i++)
      stimMem[i] = ~64'(i);
    $readmemh("bench/rtsStim.txt", stimMem);
    repeat (2) @(posedge macCoreTxClk);
    @(negedge macCoreTxClk);
    macCoreClkHardRst_n = 1'b1;
    @(posedge macCoreTxClk);
    checkValue("rtsDone_p after reset", 64'(rtsDone_p), 64'd0);
    checkValue("rtsTxStart_p after reset", 64'(rtsTxStart_p), 64'd0);
    checkValue("rtsFCSStart_p after reset", 64'(rtsFCSStart_p), 64'd0);
    checkValue("rtsFCSShiftTx after reset", 64'(rtsFCSShiftTx), 64'd0);
    checkValue("rtsFCSDInValidTx after reset", 64'(rtsFCSDInValidTx), 64'd0);
    checkValue("rtsFCSEnable after reset", 64'(rtsFCSEnable), 64'd0);
    @(negedge macCoreTxClk);
    rec = 0;
    while (rec < maxRecords && stimMem[rec*recWords+5] < 64'd3)
    begin
      runRecord(rec);
      rec++;
    end
    if (rec == 0)
    begin
      $display("no frame records could be read from the stimulus file");
      otherErrCount++;
    end
    $display("records %0d, checks %0d, mismatches %0d, other errors %0d",
             rec, checkCount, mismatchCount, otherErrCount);
    if (mismatchCount == 0 && otherErrCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- hdl/rtsFormatter.sv
`timescale 1ns/1ps

module rtsFormatter (
  // Clock and resets
  input  logic        macCoreTxClk,
  input  logic        macCoreClkHardRst_n,
  input  logic        macCoreTxClkSoftRst_n,

  // MAC controller
  input  logic [47:0] destAddr,
  input  logic [47:0] srcAddr,
  input  logic [15:0] duration,
  input  logic        txBWSignaling,
  input  logic        pwrMgt,
  input  logic        sendRTS_p,
  input  logic        sendOnPIFS,
  input  logic        sendOnSIFS,
  output logic        rtsDone_p,
  // MAC-PHY start
  output logic        rtsTxStart_p,

  // Timers
  input  logic        tickSIFS,
  input  logic        tickPIFS_p,
  input  logic        tickSlot_p,

  // FCS engine
  input  logic        fcsBusy,
  input  logic        fcsEnd_p,
  output logic        rtsFCSEnable,
  output logic        rtsFCSStart_p,
  output logic        rtsFCSShiftTx,
  output logic [7:0]  rtsFCSDInTx,
  output logic        rtsFCSDInValidTx
);

  import rtsPkg::*;

  // Trigger to sequencer
  logic          armed;
  // Sequencer back to trigger
  logic          seqActive;
  // Sequencer to byte mux
  rtsFieldPosT   fieldPos;
  // Frame values bundled for the mux
  rtsFrameParamT frameParam;

  assign frameParam = '{
    destAddr:    destAddr,
    srcAddr:     srcAddr,
    duration:    duration,
    bwSignaling: txBWSignaling,
    pwrMgt:      pwrMgt
  };

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  rtsIfsTrigger u_ifsTrigger (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .sendRTS_p             (sendRTS_p),
    .sendOnPIFS            (sendOnPIFS),
    .sendOnSIFS            (sendOnSIFS),
    .tickSIFS              (tickSIFS),
    .tickPIFS_p            (tickPIFS_p),
    .tickSlot_p            (tickSlot_p),
    .seqActive             (seqActive),
    .armed                 (armed),
    .txStart               (rtsTxStart_p)
  );

  // Field sequencing and FCS control
  rtsFieldSequencer u_fieldSequencer (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .txStart               (rtsTxStart_p),
    .armed                 (armed),
    .fcsBusy               (fcsBusy),
    .fcsEnd_p              (fcsEnd_p),
    .fieldPos              (fieldPos),
    .seqActive             (seqActive),
    .rtsFCSStart_p         (rtsFCSStart_p),
    .rtsFCSShiftTx         (rtsFCSShiftTx),
    .rtsFCSDInValidTx      (rtsFCSDInValidTx),
    .rtsFCSEnable          (rtsFCSEnable),
    .rtsDone_p             (rtsDone_p)
  );

  // Output side
  rtsByteMux u_byteMux (
    .fieldPos    (fieldPos),
    .frameParam  (frameParam),
    .rtsFCSDInTx (rtsFCSDInTx)
  );

endmodule

//--- hdl/rtsByteMux.sv
`timescale 1ns/1ps

module rtsByteMux (
  // Current field and byte index
  input  rtsPkg::rtsFieldPosT   fieldPos,
  // Values of the frame being sent
  input  rtsPkg::rtsFrameParamT frameParam,
  // Byte to the FCS engine
  output logic [7:0]            rtsFCSDInTx
);

  import rtsPkg::*;

  // Frame Control word for this frame
  rtsFrameCtrlU frameCtrl;
  // First TA byte, bandwidth bit applied
  logic [7:0]   taFirstByte;

  ////////////////////////////////////////
  // Address byte select
  ////////////////////////////////////////

  // Byte 0 is the low byte, sent first
  function automatic logic [7:0] addrByte(input logic [47:0] addr, input logic [2:0] idx);
    logic [7:0] sel;
    case (idx)
      3'd0:    sel = addr[7:0];
      3'd1:    sel = addr[15:8];
      3'd2:    sel = addr[23:16];
      3'd3:    sel = addr[31:24];
      3'd4:    sel = addr[39:32];
      3'd5:    sel = addr[47:40];
      // Beyond the address length
      default: sel = 8'd0;
    endcase
    return sel;
  endfunction

  ////////////////////////////////////////
  // Frame Control build
  ////////////////////////////////////////

  always_comb
  begin
    frameCtrl.fields.protoVer       = protocolVersion;
    frameCtrl.fields.frameType      = ctrlFrameType;
    frameCtrl.fields.subtype        = rtsSubtype;
    // No distribution system bits in a control frame
    frameCtrl.fields.toDs           = 1'b0;
    frameCtrl.fields.fromDs         = 1'b0;
    frameCtrl.fields.moreFrag       = 1'b0;
    frameCtrl.fields.retry          = 1'b0;
    // Only flag that can be set
    frameCtrl.fields.pwrMgt         = frameParam.pwrMgt;
    frameCtrl.fields.moreData       = 1'b0;
    frameCtrl.fields.protectedFrame = 1'b0;
    frameCtrl.fields.order          = 1'b0;
  end

  // Bandwidth signaling rides on the individual/group bit of TA
  assign taFirstByte = {frameParam.srcAddr[7:1], frameParam.srcAddr[0] | frameParam.bwSignaling};

  ////////////////////////////////////////
  // Output byte select
  ////////////////////////////////////////

  always_comb
  begin
    case (fieldPos.field)
      fieldFc1:
        rtsFCSDInTx = frameCtrl.bytes[0];
      fieldFc2:
        rtsFCSDInTx = frameCtrl.bytes[1];
      // Duration low byte first
      fieldDuration:
        rtsFCSDInTx = fieldPos.byteIdx[0] ? frameParam.duration[15:8] :
                                            frameParam.duration[7:0];
      fieldRa:
        rtsFCSDInTx = addrByte(frameParam.destAddr, fieldPos.byteIdx);
      fieldTa:
        if (fieldPos.byteIdx == 3'd0)
          rtsFCSDInTx = taFirstByte;
        else
          rtsFCSDInTx = addrByte(frameParam.srcAddr, fieldPos.byteIdx);
      // No data outside the header fields
      default:
        rtsFCSDInTx = 8'd0;
    endcase
  end

endmodule

//--- hdl/rtsFieldSequencer.sv
`timescale 1ns/1ps

module rtsFieldSequencer (
  // Clock and resets
  input  logic               macCoreTxClk,
  input  logic               macCoreClkHardRst_n,
  input  logic               macCoreTxClkSoftRst_n,

  // From the interframe trigger
  input  logic               txStart,
  input  logic               armed,

  // From the FCS engine
  input  logic               fcsBusy,
  input  logic               fcsEnd_p,

  // Position for the byte mux
  output rtsPkg::rtsFieldPosT fieldPos,
  // Frame in progress, back to the trigger
  output logic               seqActive,

  // FCS engine control
  output logic               rtsFCSStart_p,
  output logic               rtsFCSShiftTx,
  output logic               rtsFCSDInValidTx,
  output logic               rtsFCSEnable,

  // End of frame to the MAC controller
  output logic               rtsDone_p
);

  import rtsPkg::*;

  // Sequencer states
  typedef enum logic [2:0] {
    seqIdle     = 3'd0,
    seqStart    = 3'd1,
    seqFc1      = 3'd2,
    seqFc2      = 3'd3,
    seqDuration = 3'd4,
    seqRa       = 3'd5,
    seqTa       = 3'd6,
    seqFcs      = 3'd7
  } seqStateT;

  seqStateT   stateCs;
  seqStateT   stateNs;
  // Byte index within a multi-byte field
  logic [2:0] byteCnt;
  // Length of the current multi-byte field
  logic [2:0] nBytes;
  logic       multiField;
  logic       dataField;
  // Last byte of a multi-byte field goes out
  logic       countDone;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      stateCs <= seqIdle;
    else if (!macCoreTxClkSoftRst_n)
      stateCs <= seqIdle;
    else
      stateCs <= stateNs;
  end

  // Every data step waits for the FCS engine to be free
  always_comb
  begin
    stateNs = stateCs;
    case (stateCs)
      seqIdle:
        if (txStart)
          stateNs = seqStart;
      // One cycle for the FCS start pulse
      seqStart:
        stateNs = seqFc1;
      seqFc1:
        if (!fcsBusy)
          stateNs = seqFc2;
      seqFc2:
        if (!fcsBusy)
          stateNs = seqDuration;
      seqDuration:
        if (countDone)
          stateNs = seqRa;
      seqRa:
        if (countDone)
          stateNs = seqTa;
      seqTa:
        if (countDone)
          stateNs = seqFcs;
      // Checksum shifted out by the engine
      seqFcs:
        if (fcsEnd_p)
          stateNs = seqIdle;
      default:
        stateNs = seqIdle;
    endcase
  end

  ////////////////////////////////////////
  // Byte counter
  ////////////////////////////////////////

  // Field length from the frame format
  always_comb
  begin
    case (stateCs)
      seqDuration: nBytes = durationByteCnt;
      seqRa:       nBytes = addrByteCnt;
      seqTa:       nBytes = addrByteCnt;
      default:     nBytes = 3'd0;
    endcase
  end

  assign multiField = (stateCs == seqDuration) || (stateCs == seqRa) || (stateCs == seqTa);
  assign dataField  = multiField || (stateCs == seqFc1) || (stateCs == seqFc2);
  assign countDone  = multiField && !fcsBusy && (byteCnt == nBytes - 3'd1);

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      byteCnt <= 3'd0;
    else if (!macCoreTxClkSoftRst_n)
      byteCnt <= 3'd0;
    else if (countDone)
      // Next field starts at its first byte
      byteCnt <= 3'd0;
    else if (multiField && !fcsBusy)
      byteCnt <= byteCnt + 3'd1;
  end

  ////////////////////////////////////////
  // Field position
  ////////////////////////////////////////

  always_comb
  begin
    fieldPos.byteIdx = byteCnt;
    case (stateCs)
      seqFc1:      fieldPos.field = fieldFc1;
      seqFc2:      fieldPos.field = fieldFc2;
      seqDuration: fieldPos.field = fieldDuration;
      seqRa:       fieldPos.field = fieldRa;
      seqTa:       fieldPos.field = fieldTa;
      seqFcs:      fieldPos.field = fieldFcs;
      default:     fieldPos.field = fieldNone;
    endcase
  end

  ////////////////////////////////////////
  // FCS control and done
  ////////////////////////////////////////

  assign seqActive        = (stateCs != seqIdle);
  assign rtsFCSStart_p    = (stateCs == seqStart);
  // Byte transfers only when the engine accepts it
  assign rtsFCSDInValidTx = dataField && !fcsBusy;
  // From the last TA transfer up to the end pulse
  assign rtsFCSShiftTx    = (stateNs == seqFcs);
  // Engine kept on while waiting for the tick too
  assign rtsFCSEnable     = armed || seqActive;

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      rtsDone_p <= 1'b0;
    else if (!macCoreTxClkSoftRst_n)
      rtsDone_p <= 1'b0;
    else
      rtsDone_p <= (stateCs == seqFcs) && fcsEnd_p;
  end

endmodule

//--- hdl/rtsIfsTrigger.sv
`timescale 1ns/1ps

module rtsIfsTrigger (
  // Clock and resets
  input  logic macCoreTxClk,
  input  logic macCoreClkHardRst_n,
  input  logic macCoreTxClkSoftRst_n,

  // Request from the MAC controller
  input  logic sendRTS_p,
  input  logic sendOnPIFS,
  input  logic sendOnSIFS,

  // Interframe ticks from the timers
  input  logic tickSIFS,
  input  logic tickPIFS_p,
  input  logic tickSlot_p,

  // Sequencer busy with a frame
  input  logic seqActive,

  // Waiting for the interframe tick
  output logic armed,
  // Transmission start, also the MAC-PHY start pulse
  output logic txStart
);

  ////////////////////////////////////////
  // Request and tick selection
  ////////////////////////////////////////

  // Tick picked by the send mode
  logic tickSel;
  // Request taken only when idle
  logic sendAccept;

  // Idle means neither armed nor sending
  assign sendAccept = sendRTS_p && !armed && !seqActive;

  // PIFS first, then SIFS, else slot boundary
  always_comb
  begin
    if (sendOnPIFS)
      tickSel = tickPIFS_p;
    else if (sendOnSIFS)
      tickSel = tickSIFS;
    else
      tickSel = tickSlot_p;
  end

  // Fires in the same cycle as the selected tick
  assign txStart = armed && tickSel;

  ////////////////////////////////////////
  // Armed flag
  ////////////////////////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      armed <= 1'b0;
    else if (!macCoreTxClkSoftRst_n)
      armed <= 1'b0;
    else if (txStart)
      // Sequencer takes over from the next cycle
      armed <= 1'b0;
    else if (sendAccept)
      armed <= 1'b1;
  end

endmodule

//--- hdl/rtsPkg.sv
package rtsPkg;

  ////////////////////////////////////////
  // Frame format constants
  ////////////////////////////////////////

  // Byte count of RA and TA
  localparam logic [2:0] addrByteCnt     = 3'd6;
  // Byte count of Duration
  localparam logic [2:0] durationByteCnt = 3'd2;

  // Frame Control codes for RTS
  localparam logic [1:0] ctrlFrameType   = 2'b01;
  localparam logic [3:0] rtsSubtype      = 4'b1011;
  localparam logic [1:0] protocolVersion = 2'b00;

  ////////////////////////////////////////
  // Shared types
  ////////////////////////////////////////

  // Field currently handed to the FCS engine
  typedef enum logic [3:0] {
    fieldNone     = 4'd0,
    fieldFc1      = 4'd1,
    fieldFc2      = 4'd2,
    fieldDuration = 4'd3,
    fieldRa       = 4'd4,
    fieldTa       = 4'd5,
    fieldFcs      = 4'd6
  } rtsFieldE;

  // Field and byte index inside that field
  typedef struct packed {
    rtsFieldE   field;
    logic [2:0] byteIdx;
  } rtsFieldPosT;

  // Per-frame values from the MAC controller
  typedef struct packed {
    logic [47:0] destAddr;
    logic [47:0] srcAddr;
    logic [15:0] duration;
    logic        bwSignaling;
    logic        pwrMgt;
  } rtsFrameParamT;

  // Frame Control word, seen as fields or as two bytes
  typedef union packed {
    struct packed {
      logic       order;
      logic       protectedFrame;
      logic       moreData;
      logic       pwrMgt;
      logic       retry;
      logic       moreFrag;
      logic       fromDs;
      logic       toDs;
      logic [3:0] subtype;
      logic [1:0] frameType;
      logic [1:0] protoVer;
    } fields;
    // bytes[0] goes out first
    logic [1:0][7:0] bytes;
  } rtsFrameCtrlU;

endpackage
